// ==== design/kiwi_pkg.sv ====
// Types shared by the main bus stages
// Imported by the decode, access and top modules
package kiwi_pkg;

    // Address regions of the main CPU map
    typedef enum logic [2:0] {
        REG_ROM,
        REG_VRAM,
        REG_RAM,
        REG_VCTRL,
        REG_BANK,
        REG_IRQACK,
        REG_PAL,
        REG_NONE
    } region_t;

    // Access stage FSM
    // IDLE waits for a decoded transfer
    // WAIT holds the selects or waits on the ROM
    // DONE raises pready for one cycle
    typedef enum logic [1:0] {
        ACC_IDLE,
        ACC_WAIT,
        ACC_DONE
    } acc_state_t;

endpackage

// ==== design/kiwi_settings.svh ====
// Bus widths and memory-map boundaries of the main CPU bus
// Included by every design file that sizes a port or decodes an address
`ifndef KIWI_SETTINGS_SVH
`define KIWI_SETTINGS_SVH

// Bus and device widths
`define KIWI_AW        16
`define KIWI_DW        8
`define KIWI_ROM_AW    17
`define KIWI_VID_AW    13
`define KIWI_RAM_AW    12
`define KIWI_UNMAPPED  8'hff

// Region boundaries, each one the first address of the next block
`define KIWI_BANKED_BASE  16'h8000
`define KIWI_VRAM_BASE    16'hc000
`define KIWI_RAM_BASE     16'he000
`define KIWI_VCTRL_BASE   16'hf000
`define KIWI_VCTRL_END    16'hf500
`define KIWI_BANK_BASE    16'hf600
`define KIWI_IRQACK_BASE  16'hf700
`define KIWI_PAL_BASE     16'hf800
`define KIWI_PAL_END      16'hfc00
`endif

// ==== design/main_addr_decode.sv ====
// Decode stage of the main bus pipeline
// Samples the APB setup phase and hands region and fields to the access stage
`timescale 1ns/1ps
`include "kiwi_settings.svh"

module main_addr_decode import kiwi_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [`KIWI_AW-1:0] paddr,
    input  logic [`KIWI_DW-1:0] pwdata,
    output logic                dec_valid,
    output region_t             dec_region,
    output logic [`KIWI_AW-1:0] dec_addr,
    output logic                dec_write,
    output logic [`KIWI_DW-1:0] dec_wdata
);

    logic    setup;
    region_t region;

    // First cycle of an APB transfer
    assign setup = psel && !penable;

    // Board memory map, checked from the bottom up
    always_comb begin
        if (paddr < `KIWI_VRAM_BASE)        region = REG_ROM;
        else if (paddr < `KIWI_RAM_BASE)    region = REG_VRAM;
        else if (paddr < `KIWI_VCTRL_BASE)  region = REG_RAM;
        else if (paddr < `KIWI_VCTRL_END)   region = REG_VCTRL;
        else if (paddr < `KIWI_BANK_BASE)   region = REG_NONE;
        else if (paddr < `KIWI_IRQACK_BASE) region = REG_BANK;
        else if (paddr < `KIWI_PAL_BASE)    region = REG_IRQACK;
        else if (paddr < `KIWI_PAL_END)     region = REG_PAL;
        else                                region = REG_NONE;
    end

    // One-cycle strobe per transfer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
            dec_write <= 1'b0;
        end else begin
            dec_valid <= setup;
            if (setup) dec_write <= pwrite;
        end
    end

    // Fields stay put until the next setup phase
    always_ff @(posedge clk) begin
        if (setup) begin
            dec_region <= region;
            dec_addr   <= paddr;
            dec_wdata  <= pwdata;
        end
    end

    // Upper map writes must never be steered to the ROM
    a_no_high_rom: assert property (@(posedge clk) disable iff (rst)
        setup && pwrite && paddr >= `KIWI_VRAM_BASE |=> dec_region != REG_ROM)
        else $error("decode: write at %h classified as ROM", $past(paddr));

endmodule

// ==== design/main_bus_access.sv ====
// Access stage of the main bus pipeline
// Drives device selects, waits for the ROM and returns read data with pready
`timescale 1ns/1ps
`include "kiwi_settings.svh"

module main_bus_access import kiwi_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dec_valid,
    input  region_t                 dec_region,
    input  logic [`KIWI_AW-1:0]     dec_addr,
    input  logic                    dec_write,
    input  logic [`KIWI_DW-1:0]     dec_wdata,
    input  logic                    rom_ok,
    input  logic [`KIWI_DW-1:0]     rom_data,
    input  logic [`KIWI_DW-1:0]     vram_dout,
    input  logic [`KIWI_DW-1:0]     pal_dout,
    input  logic [`KIWI_DW-1:0]     ram_q,
    output logic [`KIWI_DW-1:0]     prdata,
    output logic                    pready,
    output logic                    rom_cs,
    output logic [`KIWI_ROM_AW-1:0] rom_addr,
    output logic                    vram_cs,
    output logic                    vctrl_cs,
    output logic                    pal_cs,
    output logic [`KIWI_VID_AW-1:0] cpu_addr,
    output logic [`KIWI_DW-1:0]     cpu_dout,
    output logic                    cpu_rnw,
    output logic                    ram_we,
    output logic [`KIWI_RAM_AW-1:0] ram_addr,
    output logic [`KIWI_DW-1:0]     ram_wdata,
    output logic                    irq_ack,
    output logic                    snd_rstn
);

    acc_state_t state;
    logic [2:0] bank;
    logic       start;
    logic       acc_end;

    assign start   = dec_valid && state == ACC_IDLE;
    // Non-ROM accesses end after one cycle, ROM reads once rom_ok shows up
    assign acc_end = state == ACC_WAIT && (!rom_cs || rom_ok);

    // Video devices and shared RAM see the decoded fields directly
    assign cpu_addr  = dec_addr[`KIWI_VID_AW-1:0];
    assign cpu_dout  = dec_wdata;
    assign cpu_rnw   = !dec_write;
    assign ram_addr  = dec_addr[`KIWI_RAM_AW-1:0];
    assign ram_wdata = dec_wdata;
    assign ram_we    = start && dec_write && dec_region == REG_RAM;

    // Upper 16kB window is banked
    assign rom_addr = dec_addr >= `KIWI_BANKED_BASE ? {bank, dec_addr[13:0]} : {1'b0, dec_addr};

    assign pready  = state == ACC_DONE;
    assign irq_ack = pready && dec_region == REG_IRQACK;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ACC_IDLE;
            rom_cs   <= 1'b0;
            vram_cs  <= 1'b0;
            vctrl_cs <= 1'b0;
            pal_cs   <= 1'b0;
            bank     <= 3'd0;
            snd_rstn <= 1'b0;
        end else begin
            // Video selects are single-cycle strobes
            vram_cs  <= 1'b0;
            vctrl_cs <= 1'b0;
            pal_cs   <= 1'b0;
            case (state)
                ACC_IDLE: if (dec_valid) begin
                    rom_cs   <= dec_region == REG_ROM && !dec_write;
                    vram_cs  <= dec_region == REG_VRAM;
                    vctrl_cs <= dec_region == REG_VCTRL;
                    pal_cs   <= dec_region == REG_PAL;
                    // Bank bits and sound CPU reset share one register
                    if (dec_write && dec_region == REG_BANK) begin
                        bank     <= dec_wdata[2:0];
                        snd_rstn <= dec_wdata[4];
                    end
                    state <= ACC_WAIT;
                end
                ACC_WAIT: if (acc_end) begin
                    rom_cs <= 1'b0;
                    state  <= ACC_DONE;
                end
                default: state <= ACC_IDLE;
            endcase
        end
    end

    // Read data captured on the last cycle of the access
    always_ff @(posedge clk) begin
        if (acc_end) begin
            case (dec_region)
                REG_ROM:             prdata <= rom_data;
                REG_VRAM, REG_VCTRL: prdata <= vram_dout;
                REG_PAL:             prdata <= pal_dout;
                REG_RAM:             prdata <= ram_q;
                default:             prdata <= `KIWI_UNMAPPED;
            endcase
        end
    end

    a_pready_pulse: assert property (@(posedge clk) disable iff (rst) pready |=> !pready)
        else $error("access: pready held longer than one cycle");

    // Only one device owns the bus at a time
    a_one_select: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, vram_cs, vctrl_cs, pal_cs, ram_we}))
        else $error("access: several selects active together");

endmodule

// ==== design/main_bus_top.sv ====
// Main CPU memory-map block with an APB slave port
// Connects decode and access stages, the shared RAM and the vblank interrupt
`timescale 1ns/1ps
`include "kiwi_settings.svh"

module main_bus_top import kiwi_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // APB slave
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`KIWI_AW-1:0]     paddr,
    input  logic [`KIWI_DW-1:0]     pwdata,
    output logic [`KIWI_DW-1:0]     prdata,
    output logic                    pready,
    input  logic                    lvbl,
    // ROM
    output logic [`KIWI_ROM_AW-1:0] rom_addr,
    output logic                    rom_cs,
    input  logic                    rom_ok,
    input  logic [`KIWI_DW-1:0]     rom_data,
    // Video devices
    output logic                    vram_cs,
    output logic                    vctrl_cs,
    output logic                    pal_cs,
    output logic [`KIWI_VID_AW-1:0] cpu_addr,
    output logic [`KIWI_DW-1:0]     cpu_dout,
    output logic                    cpu_rnw,
    input  logic [`KIWI_DW-1:0]     vram_dout,
    input  logic [`KIWI_DW-1:0]     pal_dout,
    // Sound CPU side of the shared RAM
    input  logic [`KIWI_RAM_AW-1:0] shr_addr,
    input  logic [`KIWI_DW-1:0]     shr_din,
    input  logic                    shr_we,
    output logic [`KIWI_DW-1:0]     shr_dout,
    output logic                    snd_rstn,
    output logic                    irq_n
);

    // Decode to access stage
    logic                    dec_valid;
    region_t                 dec_region;
    logic [`KIWI_AW-1:0]     dec_addr;
    logic                    dec_write;
    logic [`KIWI_DW-1:0]     dec_wdata;
    // Main side of the shared RAM
    logic                    ram_we;
    logic [`KIWI_RAM_AW-1:0] ram_addr;
    logic [`KIWI_DW-1:0]     ram_wdata;
    logic [`KIWI_DW-1:0]     ram_q;
    logic                    irq_ack;

    main_addr_decode u_decode (.*);

    main_bus_access u_access (.*);

    shared_comm_ram u_comm (
        .clk     (clk),
        .addr_a  (ram_addr),
        .wdata_a (ram_wdata),
        .we_a    (ram_we),
        .addr_b  (shr_addr),
        .wdata_b (shr_din),
        .we_b    (shr_we),
        .q_a     (ram_q),
        .q_b     (shr_dout)
    );

    vblank_irq u_irq (.*);

endmodule

// ==== design/shared_comm_ram.sv ====
// Communication RAM between the main CPU and the sound CPU
// True dual port, registered reads on both sides, port A wins write clashes
`timescale 1ns/1ps
`include "kiwi_settings.svh"

module shared_comm_ram (
    input  logic                    clk,
    input  logic [`KIWI_RAM_AW-1:0] addr_a,
    input  logic [`KIWI_DW-1:0]     wdata_a,
    input  logic                    we_a,
    input  logic [`KIWI_RAM_AW-1:0] addr_b,
    input  logic [`KIWI_DW-1:0]     wdata_b,
    input  logic                    we_b,
    output logic [`KIWI_DW-1:0]     q_a,
    output logic [`KIWI_DW-1:0]     q_b
);

    logic [`KIWI_DW-1:0] mem [0:(1<<`KIWI_RAM_AW)-1];
    logic                clash;

    // Same word written from both sides in one cycle
    assign clash = we_a && we_b && addr_a == addr_b;

    always_ff @(posedge clk) begin
        // Sound side loses on a clash
        if (we_b && !clash) mem[addr_b] <= wdata_b;
        if (we_a) mem[addr_a] <= wdata_a;
        // Old data on a read during write
        q_a <= mem[addr_a];
        q_b <= mem[addr_b];
    end

endmodule

// ==== design/vblank_irq.sv ====
// Main CPU interrupt latch
// Set at the start of vertical blank, cleared by an acknowledge access
`timescale 1ns/1ps

module vblank_irq (
    input  logic clk,
    input  logic rst,
    input  logic lvbl,
    input  logic irq_ack,
    output logic irq_n
);

    logic lvbl_l;
    logic vb_start;

    // Blank starts when lvbl drops
    assign vb_start = lvbl_l && !lvbl;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // No edge reported straight out of reset
            lvbl_l <= 1'b0;
            irq_n  <= 1'b1;
        end else begin
            lvbl_l <= lvbl;
            // A new blank beats a late acknowledge
            if (vb_start) irq_n <= 1'b0;
            else if (irq_ack) irq_n <= 1'b1;
        end
    end

endmodule

// ==== files.f ====
+incdir+design
design/kiwi_pkg.sv
design/main_addr_decode.sv
design/main_bus_access.sv
design/shared_comm_ram.sv
design/vblank_irq.sv
design/main_bus_top.sv
verif/main_bus_tb.sv

// ==== verif/main_bus_tb.sv ====
// Testbench for the main CPU memory-map block
// Acts as the APB requester, models ROM and video devices, checks with assertions
`timescale 1ns/1ps

module main_bus_tb import kiwi_pkg::*;;

    logic        clk = 1'b0;
    logic        rst;
    logic        psel, penable, pwrite, lvbl;
    logic [15:0] paddr;
    logic [7:0]  pwdata, prdata, rom_data, cpu_dout, vram_dout, pal_dout;
    logic        pready, rom_cs, vram_cs, vctrl_cs, pal_cs, cpu_rnw;
    logic        rom_ok = 1'b0;
    logic [16:0] rom_addr;
    logic [12:0] cpu_addr;
    logic [11:0] shr_addr;
    logic [7:0]  shr_din, shr_dout;
    logic        shr_we, snd_rstn, irq_n;

    // Expected side of the current transfer
    string       test_name = "reset";
    logic [15:0] exp_addr = '0;
    logic [7:0]  exp_wdata = '0;
    logic [7:0]  exp_rdata = '0;
    logic        exp_write = 1'b0;
    logic        chk_read = 1'b0;
    region_t     exp_region = REG_NONE;
    int          exp_sel = 0;
    logic [2:0]  exp_cs = '0;
    int          sel_cnt = 0;
    logic        shr_chk = 1'b0;
    logic [7:0]  shr_exp = '0;
    // Reference state built from the bus traffic
    logic [2:0]  bank_model = 3'd0;
    logic [7:0]  ram_model [0:4095];
    integer      seed;
    int          rom_wait;
    logic        rom_armed = 1'b0;
    int          cycles = 0;
    int          mismatch_errs = 0;
    int          other_errs = 0;

    main_bus_top dut_i (.*);

    always #4 clk = ~clk;

    // ROM data pattern and video read data
    assign rom_data  = rom_addr[7:0] ^ rom_addr[16:9];
    assign vram_dout = cpu_addr[7:0] + 8'd1;
    assign pal_dout  = ~cpu_addr[7:0];

    // ROM answers 0 to 3 cycles after rom_cs rises
    always @(posedge clk) begin
        #1;
        if (!rom_cs) begin
            rom_ok    = 1'b0;
            rom_armed = 1'b0;
        end else if (!rom_armed) begin
            rom_armed = 1'b1;
            rom_wait  = $random(seed) & 3;
            rom_ok    = rom_wait == 0;
        end else if (!rom_ok) begin
            rom_wait = rom_wait - 1;
            rom_ok   = rom_wait == 0;
        end
    end

    // Video select pulses seen since the last setup phase
    always @(posedge clk) begin
        if (psel && !penable) sel_cnt <= 0;
        else if (vram_cs || vctrl_cs || pal_cs) sel_cnt <= sel_cnt + 1;
    end

    // Run limit for about 60 transfers of at most 8 cycles each
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 4000) begin
            $display("timeout: run reached 4000 cycles without finishing");
            $display("Verification failed");
            $finish;
        end
    end

    function automatic region_t region_of(input logic [15:0] a);
        case (a) inside
            [16'h0000:16'hbfff]: region_of = REG_ROM;
            [16'hc000:16'hdfff]: region_of = REG_VRAM;
            [16'he000:16'hefff]: region_of = REG_RAM;
            [16'hf000:16'hf4ff]: region_of = REG_VCTRL;
            [16'hf600:16'hf6ff]: region_of = REG_BANK;
            [16'hf700:16'hf7ff]: region_of = REG_IRQACK;
            [16'hf800:16'hfbff]: region_of = REG_PAL;
            default:             region_of = REG_NONE;
        endcase
    endfunction

    // Read value from the memory map and the device models
    function automatic logic [7:0] model_read(input logic [15:0] a);
        logic [16:0] ra;
        ra = a < 16'h8000 ? {1'b0, a} : {bank_model, a[13:0]};
        case (region_of(a))
            REG_ROM:             model_read = ra[7:0] ^ ra[16:9];
            REG_VRAM, REG_VCTRL: model_read = a[7:0] + 8'd1;
            REG_PAL:             model_read = ~a[7:0];
            REG_RAM:             model_read = ram_model[a[11:0]];
            default:             model_read = 8'hff;
        endcase
    endfunction

    // One APB transfer that returns 1 ns after the completing edge
    task automatic apb_xfer(input logic wr, input logic [15:0] a, input logic [7:0] d,
                            input string name);
        test_name  = name;
        exp_addr   = a;
        exp_write  = wr;
        exp_wdata  = d;
        exp_region = region_of(a);
        exp_rdata  = wr ? 8'h00 : model_read(a);
        exp_sel    = exp_region inside {REG_VRAM, REG_VCTRL, REG_PAL};
        exp_cs     = {exp_region == REG_VRAM, exp_region == REG_VCTRL, exp_region == REG_PAL};
        chk_read   = !wr;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = d;
        @(posedge clk);
        #1 penable = 1'b1;
        forever begin
            @(posedge clk);
            if (pready) break;
        end
        #1;
        psel     = 1'b0;
        penable  = 1'b0;
        chk_read = 1'b0;
        if (wr && exp_region == REG_BANK) bank_model = d[2:0];
        if (wr && exp_region == REG_RAM) ram_model[a[11:0]] = d;
    endtask

    task automatic sound_write(input logic [11:0] a, input logic [7:0] d);
        shr_addr = a;
        shr_din  = d;
        shr_we   = 1'b1;
        @(posedge clk);
        #1 shr_we = 1'b0;
        ram_model[a] = d;
    endtask

    // Port B read with data one cycle after the address
    task automatic sound_read(input logic [11:0] a, input string name);
        test_name = name;
        shr_addr  = a;
        shr_exp   = ram_model[a];
        shr_chk   = 1'b1;
        @(posedge clk);
        #1 shr_chk = 1'b0;
        @(posedge clk);
        #1;
    endtask

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        pready && chk_read |-> prdata == exp_rdata)
        else begin
            mismatch_errs++;
            $display("mismatch %s: expected %h actual %h", test_name, exp_rdata,
                     $sampled(prdata));
        end

    a_select_count: assert property (@(posedge clk) disable iff (rst)
        pready |-> sel_cnt == exp_sel)
        else begin
            mismatch_errs++;
            $display("mismatch %s select pulses: expected %0d actual %0d", test_name,
                     exp_sel, $sampled(sel_cnt));
        end

    // Only the select of the addressed video device fires
    a_select_region: assert property (@(posedge clk) disable iff (rst)
        vram_cs || vctrl_cs || pal_cs |-> {vram_cs, vctrl_cs, pal_cs} == exp_cs)
        else begin
            mismatch_errs++;
            $display("mismatch %s selects: expected %b actual %b", test_name, exp_cs,
                     $sampled({vram_cs, vctrl_cs, pal_cs}));
        end

    a_select_width: assert property (@(posedge clk) disable iff (rst)
        vram_cs || vctrl_cs || pal_cs |=> !(vram_cs || vctrl_cs || pal_cs))
        else begin
            other_errs++;
            $display("a video select stayed high for more than one cycle");
        end

    // ROM writes never reach the ROM
    a_rom_write_ignored: assert property (@(posedge clk) disable iff (rst)
        rom_cs |-> !exp_write)
        else begin
            other_errs++;
            $display("rom_cs was raised for a write transfer");
        end

    a_video_addr: assert property (@(posedge clk) disable iff (rst)
        vram_cs || vctrl_cs || pal_cs |-> cpu_addr == exp_addr[12:0])
        else begin
            mismatch_errs++;
            $display("mismatch %s cpu_addr: expected %h actual %h", test_name,
                     exp_addr[12:0], $sampled(cpu_addr));
        end

    // Write data and direction seen by the video devices
    a_video_write: assert property (@(posedge clk) disable iff (rst)
        (vram_cs || vctrl_cs || pal_cs) && exp_write |-> cpu_dout == exp_wdata && !cpu_rnw)
        else begin
            mismatch_errs++;
            $display("mismatch %s cpu_dout: expected %h actual %h", test_name, exp_wdata,
                     $sampled(cpu_dout));
        end

    a_snd_rstn: assert property (@(posedge clk) disable iff (rst)
        pready && exp_write && exp_region == REG_BANK |-> snd_rstn == exp_wdata[4])
        else begin
            mismatch_errs++;
            $display("mismatch %s snd_rstn: expected %b actual %b", test_name, exp_wdata[4],
                     $sampled(snd_rstn));
        end

    a_reset_idle: assert property (@(posedge clk) $fell(rst) |->
        !snd_rstn && !pready && !rom_cs && !vram_cs && !vctrl_cs && !pal_cs && irq_n)
        else begin
            other_errs++;
            $display("outputs were not idle when reset was released");
        end

    a_irq_set: assert property (@(posedge clk) disable iff (rst) $fell(lvbl) |=> !irq_n)
        else begin
            other_errs++;
            $display("irq_n did not fall after vertical blank started");
        end

    a_irq_ack: assert property (@(posedge clk) disable iff (rst)
        pready && exp_region == REG_IRQACK |=> irq_n)
        else begin
            other_errs++;
            $display("irq_n did not rise after the acknowledge access");
        end

    a_irq_hold: assert property (@(posedge clk) disable iff (rst)
        irq_n && !$fell(lvbl) |=> irq_n)
        else begin
            other_errs++;
            $display("irq_n fell without a new vertical blank");
        end

    a_shared_port_b: assert property (@(posedge clk) disable iff (rst)
        shr_chk |=> shr_dout == shr_exp)
        else begin
            mismatch_errs++;
            $display("mismatch %s: expected %h actual %h", test_name, shr_exp,
                     $sampled(shr_dout));
        end

    initial begin
        logic [31:0] rnd;
        int          i;
        int          j;
        seed     = 32'he35b_fc40;
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        lvbl     = 1'b1;
        shr_addr = '0;
        shr_din  = '0;
        shr_we   = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        // Banks 0, 5, 2, 7 with the sound reset bit toggling
        for (i = 0; i < 4; i++) begin
            apb_xfer(1'b1, 16'hf600, {3'b000, i[0], 1'b0, 3'(i * 5)}, "bank_write");
            for (j = 0; j < 3; j++) begin
                rnd = $random(seed);
                apb_xfer(1'b0, {1'b0, rnd[14:0]}, 8'h00, "rom_fixed");
                apb_xfer(1'b0, {2'b10, rnd[29:16]}, 8'h00, "rom_banked");
            end
            apb_xfer(1'b0, 16'h8000, 8'h00, "rom_bank_low_edge");
            apb_xfer(1'b0, 16'hbfff, 8'h00, "rom_bank_high_edge");
        end
        apb_xfer(1'b0, 16'h7fff, 8'h00, "rom_fixed_top");
        // Shared RAM from both sides
        apb_xfer(1'b1, 16'he123, 8'h5a, "ram_write");
        apb_xfer(1'b0, 16'he123, 8'h00, "ram_read_back");
        sound_read(12'h123, "ram_port_b_read");
        sound_write(12'h456, 8'ha7);
        apb_xfer(1'b0, 16'he456, 8'h00, "ram_from_port_b");
        // Video device reads then writes
        rnd = $random(seed);
        apb_xfer(1'b0, 16'hc000, 8'h00, "vram_read_low");
        apb_xfer(1'b0, 16'hdfff, 8'h00, "vram_read_high");
        apb_xfer(1'b0, {3'b110, rnd[12:0]}, 8'h00, "vram_read_rand");
        apb_xfer(1'b0, 16'hf000, 8'h00, "vctrl_read_low");
        apb_xfer(1'b0, 16'hf4ff, 8'h00, "vctrl_read_high");
        apb_xfer(1'b0, 16'hf800, 8'h00, "pal_read_low");
        apb_xfer(1'b0, 16'hfbff, 8'h00, "pal_read_high");
        apb_xfer(1'b1, 16'hc010, 8'ha5, "vram_write");
        apb_xfer(1'b1, 16'hf010, 8'h3c, "vctrl_write");
        apb_xfer(1'b1, 16'hf810, 8'hc3, "pal_write");
        // Vertical blank interrupt and its acknowledge
        lvbl = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        apb_xfer(1'b0, 16'hf700, 8'h00, "irq_ack");
        repeat (4) @(posedge clk);
        #1 lvbl = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        // Unmapped holes and ignored ROM writes
        apb_xfer(1'b0, 16'hf500, 8'h00, "unmapped_f500");
        apb_xfer(1'b0, 16'hfc00, 8'h00, "unmapped_fc00");
        apb_xfer(1'b0, 16'hffff, 8'h00, "unmapped_ffff");
        apb_xfer(1'b1, 16'h1234, 8'h55, "rom_write_fixed");
        apb_xfer(1'b0, 16'h1234, 8'h00, "rom_after_write");
        apb_xfer(1'b1, 16'h9abc, 8'haa, "rom_write_banked");
        apb_xfer(1'b0, 16'h9abc, 8'h00, "rom_banked_after_write");
        repeat (3) @(posedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
        if (mismatch_errs + other_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
